/* include/lc4_defines.svh */
`ifndef LC4_DEFINES_SVH
`define LC4_DEFINES_SVH

`default_nettype none

// data and instruction width
`define LC4_WORD_W 16

// architectural registers, select width comes from this
`define LC4_NREGS 8

// fetch address after reset
`define LC4_BOOT_PC 16'h8200

// stall codes on the writeback trace
`define LC4_STALL_NONE   2'd0
`define LC4_STALL_BRANCH 2'd2
`define LC4_STALL_LOAD   2'd3

`default_nettype wire

`endif

/* design/lc4_isa_pkg.sv */
`default_nettype none

package lc4_isa_pkg;

   // opcodes of the supported subset, NOP is BR with an empty mask
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_AND   = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   // subop field values, register form
   localparam logic [2:0] SUBOP_ADD = 3'b000;
   localparam logic [2:0] SUBOP_SUB = 3'b010;
   localparam logic [2:0] SUBOP_AND = 3'b000;

   typedef struct packed {
      logic n;
      logic z;
      logic p;
   } nzp_t;

   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] subop;
      logic [2:0] rt;
   } r_form_t;

   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rd;      // rt for STR
      logic [2:0] rs;
      logic [5:0] imm6;    // arith: [5] picks imm5 form, [4:0] imm5
   } i_form_t;

   typedef struct packed {
      opcode_e    opcode;
      nzp_t       nzp;     // branch mask, rd for CONST
      logic [8:0] imm9;
   } b_form_t;

   typedef union packed {
      r_form_t r_form;
      i_form_t i_form;
      b_form_t b_form;
   } insn_u;

endpackage

`default_nettype wire

/* design/lc4_pipe_pkg.sv */
`include "lc4_defines.svh"
`default_nettype none

package lc4_pipe_pkg;

   localparam int RSEL_W = $clog2(`LC4_NREGS);

   typedef logic [RSEL_W-1:0] rsel_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_ADDI,
      ALU_CONST,
      ALU_MEMADDR,      // base + imm6
      ALU_BRTARGET      // pc + 1 + imm9
   } alu_op_e;

   // all zero is a bubble
   typedef struct packed {
      rsel_t   rs_sel;
      logic    rs_re;
      rsel_t   rt_sel;
      logic    rt_re;
      rsel_t   wsel;
      logic    regfile_we;
      logic    nzp_we;
      logic    is_load;
      logic    is_store;
      logic    is_branch;
      alu_op_e alu_op;
   } ctrl_t;

   typedef logic [1:0] stall_t;

endpackage

`default_nettype wire

/* design/lc4_wb_if.sv */
`include "lc4_defines.svh"
`default_nettype none

interface lc4_wb_if import lc4_pipe_pkg::*; ();

   logic                   we;
   rsel_t                  wsel;
   logic [`LC4_WORD_W-1:0] data;   // load data or alu result, already muxed
   logic                   load;   // W holds a load, for store data bypass

   modport source (output we, output wsel, output data, output load);

   modport sink (input we, input wsel, input data, input load);

endinterface

`default_nettype wire

/* design/lc4_decoder.sv */
`default_nettype none

module lc4_decoder import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  insn_u i_insn,
   output ctrl_t o_ctrl
);

   always_comb begin
      o_ctrl = '0;   // anything not matched below stays a nop
      case (i_insn.r_form.opcode)
         OP_BR: begin
            o_ctrl.is_branch = |i_insn.b_form.nzp;   // empty mask is NOP
            o_ctrl.alu_op    = ALU_BRTARGET;
         end
         OP_ARITH: begin
            if (i_insn.i_form.imm6[5]) begin
               o_ctrl.rs_sel     = i_insn.i_form.rs;
               o_ctrl.rs_re      = 1'b1;
               o_ctrl.wsel       = i_insn.i_form.rd;
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.nzp_we     = 1'b1;
               o_ctrl.alu_op     = ALU_ADDI;
            end else if (i_insn.r_form.subop == SUBOP_ADD ||
                         i_insn.r_form.subop == SUBOP_SUB) begin
               o_ctrl.rs_sel     = i_insn.r_form.rs;
               o_ctrl.rs_re      = 1'b1;
               o_ctrl.rt_sel     = i_insn.r_form.rt;
               o_ctrl.rt_re      = 1'b1;
               o_ctrl.wsel       = i_insn.r_form.rd;
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.nzp_we     = 1'b1;
               o_ctrl.alu_op     = (i_insn.r_form.subop == SUBOP_SUB) ? ALU_SUB : ALU_ADD;
            end
         end
         OP_AND: begin
            if (i_insn.r_form.subop == SUBOP_AND) begin
               o_ctrl.rs_sel     = i_insn.r_form.rs;
               o_ctrl.rs_re      = 1'b1;
               o_ctrl.rt_sel     = i_insn.r_form.rt;
               o_ctrl.rt_re      = 1'b1;
               o_ctrl.wsel       = i_insn.r_form.rd;
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.nzp_we     = 1'b1;
               o_ctrl.alu_op     = ALU_AND;
            end
         end
         OP_LDR: begin
            o_ctrl.rs_sel     = i_insn.i_form.rs;
            o_ctrl.rs_re      = 1'b1;
            o_ctrl.wsel       = i_insn.i_form.rd;
            o_ctrl.regfile_we = 1'b1;   // no nzp write for loads here
            o_ctrl.is_load    = 1'b1;
            o_ctrl.alu_op     = ALU_MEMADDR;
         end
         OP_STR: begin
            o_ctrl.rs_sel   = i_insn.i_form.rs;
            o_ctrl.rs_re    = 1'b1;
            o_ctrl.rt_sel   = i_insn.i_form.rd;   // store data sits in [11:9]
            o_ctrl.rt_re    = 1'b1;
            o_ctrl.is_store = 1'b1;
            o_ctrl.alu_op   = ALU_MEMADDR;
         end
         OP_CONST: begin
            o_ctrl.wsel       = i_insn.i_form.rd;
            o_ctrl.regfile_we = 1'b1;
            o_ctrl.nzp_we     = 1'b1;
            o_ctrl.alu_op     = ALU_CONST;
         end
         default: begin
            o_ctrl = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* design/lc4_alu.sv */
`include "lc4_defines.svh"
`default_nettype none

module lc4_alu import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  insn_u                  i_insn,
   input  logic [`LC4_WORD_W-1:0] i_pc,
   input  logic [`LC4_WORD_W-1:0] i_rs_data,
   input  logic [`LC4_WORD_W-1:0] i_rt_data,
   input  alu_op_e                i_op,
   output logic [`LC4_WORD_W-1:0] o_result
);

   localparam int W = `LC4_WORD_W;

   logic [W-1:0] imm5_sx;
   logic [W-1:0] imm6_sx;
   logic [W-1:0] imm9_sx;

   // sign extended immediates
   assign imm5_sx = W'(signed'(i_insn.i_form.imm6[4:0]));
   assign imm6_sx = W'(signed'(i_insn.i_form.imm6));
   assign imm9_sx = W'(signed'(i_insn.b_form.imm9));

   always_comb begin
      case (i_op)
         ALU_ADD:      o_result = i_rs_data + i_rt_data;
         ALU_SUB:      o_result = i_rs_data - i_rt_data;
         ALU_AND:      o_result = i_rs_data & i_rt_data;
         ALU_ADDI:     o_result = i_rs_data + imm5_sx;
         ALU_CONST:    o_result = imm9_sx;
         ALU_MEMADDR:  o_result = i_rs_data + imm6_sx;
         ALU_BRTARGET: o_result = i_pc + W'(1) + imm9_sx;
         default:      o_result = i_rs_data + i_rt_data;
      endcase
   end

endmodule

`default_nettype wire

/* design/lc4_regfile.sv */
`include "lc4_defines.svh"
`default_nettype none

module lc4_regfile import lc4_pipe_pkg::*; (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   input  rsel_t                  i_rs_sel,
   input  rsel_t                  i_rt_sel,
   output logic [`LC4_WORD_W-1:0] o_rs_data,
   output logic [`LC4_WORD_W-1:0] o_rt_data,
   lc4_wb_if.sink                 wb
);

   logic [`LC4_WORD_W-1:0] regs [`LC4_NREGS];

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int i = 0; i < `LC4_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.we) begin
         regs[wb.wsel] <= wb.data;
      end
   end

   // write-through, D sees what W retires this cycle
   assign o_rs_data = (wb.we && wb.wsel == i_rs_sel) ? wb.data : regs[i_rs_sel];
   assign o_rt_data = (wb.we && wb.wsel == i_rt_sel) ? wb.data : regs[i_rt_sel];

endmodule

`default_nettype wire

/* design/lc4_hazard_unit.sv */
`include "lc4_defines.svh"
`default_nettype none

module lc4_hazard_unit import lc4_pipe_pkg::*; (
   input  ctrl_t                  i_d_ctrl,
   input  ctrl_t                  i_x_ctrl,
   input  ctrl_t                  i_m_ctrl,
   input  logic [`LC4_WORD_W-1:0] i_m_result,
   input  logic [`LC4_WORD_W-1:0] i_x_rs_data,
   input  logic [`LC4_WORD_W-1:0] i_x_rt_data,
   input  logic [`LC4_WORD_W-1:0] i_m_store_data,
   lc4_wb_if.sink                 wb,
   output logic                   o_load_stall,
   output logic [`LC4_WORD_W-1:0] o_x_rs_fwd,
   output logic [`LC4_WORD_W-1:0] o_x_rt_fwd,
   output logic [`LC4_WORD_W-1:0] o_m_store_data
);

   logic m_fwd_ok;   // M result is a real register value

   // a load in M only has its address, the data comes a cycle later
   assign m_fwd_ok = i_m_ctrl.regfile_we && !i_m_ctrl.is_load;

   // store data is left out, WM covers it
   assign o_load_stall = i_x_ctrl.is_load && i_x_ctrl.regfile_we &&
      ((i_d_ctrl.rs_re && i_d_ctrl.rs_sel == i_x_ctrl.wsel) ||
       (i_d_ctrl.rt_re && !i_d_ctrl.is_store && i_d_ctrl.rt_sel == i_x_ctrl.wsel));

   // MX wins over WX, the younger producer
   function automatic logic [`LC4_WORD_W-1:0] fwd_pick(
      input rsel_t                  sel,
      input logic [`LC4_WORD_W-1:0] reg_data
   );
      if (m_fwd_ok && i_m_ctrl.wsel == sel) begin
         return i_m_result;
      end else if (wb.we && wb.wsel == sel) begin
         return wb.data;
      end
      return reg_data;
   endfunction

   assign o_x_rs_fwd = fwd_pick(i_x_ctrl.rs_sel, i_x_rs_data);
   assign o_x_rt_fwd = fwd_pick(i_x_ctrl.rt_sel, i_x_rt_data);

   // WM, load in W feeding the store in M
   assign o_m_store_data = (wb.we && wb.load && i_m_ctrl.is_store &&
                            wb.wsel == i_m_ctrl.rt_sel) ? wb.data : i_m_store_data;

endmodule

`default_nettype wire

/* design/lc4_branch_unit.sv */
`include "lc4_defines.svh"
`default_nettype none

module lc4_branch_unit import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   input  ctrl_t                  i_x_ctrl,
   input  insn_u                  i_x_insn,
   input  logic [`LC4_WORD_W-1:0] i_x_result,
   output logic                   o_taken
);

   logic res_neg;
   logic res_zero;
   nzp_t nzp_new;
   nzp_t nzp_q;

   assign res_neg  = i_x_result[`LC4_WORD_W-1];
   assign res_zero = (i_x_result == '0);
   assign nzp_new  = '{n: res_neg, z: res_zero, p: !res_neg && !res_zero};

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         nzp_q <= '0;
      end else if (i_x_ctrl.nzp_we) begin
         nzp_q <= nzp_new;
      end
   end

   // nzp_q was written by the instruction just ahead, now in M
   assign o_taken = i_x_ctrl.is_branch && (|(i_x_insn.b_form.nzp & nzp_q));

endmodule

`default_nettype wire

/* design/lc4_core.sv */
`include "lc4_defines.svh"
`default_nettype none

module lc4_core import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   output logic [`LC4_WORD_W-1:0] o_imem_addr,
   input  logic [`LC4_WORD_W-1:0] i_imem_data,
   output logic [`LC4_WORD_W-1:0] o_dmem_addr,
   output logic                   o_dmem_we,
   output logic [`LC4_WORD_W-1:0] o_dmem_wdata,
   input  logic [`LC4_WORD_W-1:0] i_dmem_rdata,
   output logic                   o_wb_valid,
   output logic [`LC4_WORD_W-1:0] o_wb_pc,
   output logic [`LC4_WORD_W-1:0] o_wb_insn,
   output logic                   o_wb_we,
   output rsel_t                  o_wb_wsel,
   output logic [`LC4_WORD_W-1:0] o_wb_data,
   output stall_t                 o_wb_stall
);

   localparam int W = `LC4_WORD_W;

   logic [W-1:0] pc_q;
   logic         load_stall;
   logic         taken;

   // valid marks a slot that came from fetch, bubbles included
   logic [W-1:0] d_pc;
   insn_u        d_insn;
   logic         d_valid;
   stall_t       d_stall;
   ctrl_t        d_ctrl;
   logic [W-1:0] d_rs_data, d_rt_data;

   logic [W-1:0] x_pc;
   insn_u        x_insn;
   logic         x_valid;
   stall_t       x_stall;
   ctrl_t        x_ctrl;
   logic [W-1:0] x_rs_data, x_rt_data;
   logic [W-1:0] x_rs_fwd, x_rt_fwd;
   logic [W-1:0] x_result;

   logic [W-1:0] m_pc;
   logic [W-1:0] m_insn;
   logic         m_valid;
   stall_t       m_stall;
   ctrl_t        m_ctrl;
   logic [W-1:0] m_result;
   logic [W-1:0] m_store_data;

   logic [W-1:0] w_pc;
   logic [W-1:0] w_insn;
   logic         w_valid;
   stall_t       w_stall;
   ctrl_t        w_ctrl;
   logic [W-1:0] w_result;
   logic [W-1:0] w_load_data;

   lc4_wb_if wb ();

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         pc_q <= `LC4_BOOT_PC;
      end else if (taken) begin
         pc_q <= x_result;   // branch target
      end else if (!load_stall) begin
         pc_q <= pc_q + W'(1);
      end
   end

   assign o_imem_addr = pc_q;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         d_insn  <= '0;
         d_valid <= 1'b0;
         d_stall <= `LC4_STALL_NONE;
      end else if (taken) begin
         d_insn  <= '0;      // squash the fetched slot
         d_valid <= 1'b1;
         d_stall <= `LC4_STALL_BRANCH;
      end else if (!load_stall) begin
         d_insn  <= i_imem_data;
         d_valid <= 1'b1;
         d_stall <= `LC4_STALL_NONE;
      end
   end

   always_ff @(posedge gwe) begin
      if (!load_stall) begin
         d_pc <= pc_q;
      end
   end

   lc4_decoder u_decoder (.i_insn(d_insn), .o_ctrl(d_ctrl));

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs_sel  (d_ctrl.rs_sel),
      .i_rt_sel  (d_ctrl.rt_sel),
      .o_rs_data (d_rs_data),
      .o_rt_data (d_rt_data),
      .wb        (wb)
   );

   // bubble into X on a load stall or a flush
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         x_insn  <= '0;
         x_ctrl  <= '0;
         x_valid <= 1'b0;
         x_stall <= `LC4_STALL_NONE;
      end else begin
         x_valid <= d_valid;
         if (taken || load_stall) begin
            x_insn  <= '0;
            x_ctrl  <= '0;
            x_stall <= taken ? `LC4_STALL_BRANCH : `LC4_STALL_LOAD;
         end else begin
            x_insn  <= d_insn;
            x_ctrl  <= d_ctrl;
            x_stall <= d_stall;
         end
      end
   end

   always_ff @(posedge gwe) begin
      x_pc      <= d_pc;
      x_rs_data <= d_rs_data;
      x_rt_data <= d_rt_data;
   end

   lc4_hazard_unit u_hazard (
      .i_d_ctrl       (d_ctrl),
      .i_x_ctrl       (x_ctrl),
      .i_m_ctrl       (m_ctrl),
      .i_m_result     (m_result),
      .i_x_rs_data    (x_rs_data),
      .i_x_rt_data    (x_rt_data),
      .i_m_store_data (m_store_data),
      .wb             (wb),
      .o_load_stall   (load_stall),
      .o_x_rs_fwd     (x_rs_fwd),
      .o_x_rt_fwd     (x_rt_fwd),
      .o_m_store_data (o_dmem_wdata)
   );

   lc4_alu u_alu (
      .i_insn    (x_insn),
      .i_pc      (x_pc),
      .i_rs_data (x_rs_fwd),
      .i_rt_data (x_rt_fwd),
      .i_op      (x_ctrl.alu_op),
      .o_result  (x_result)
   );

   lc4_branch_unit u_branch (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_x_ctrl   (x_ctrl),
      .i_x_insn   (x_insn),
      .i_x_result (x_result),
      .o_taken    (taken)
   );

   // M and W just shift
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         m_insn  <= '0;
         m_ctrl  <= '0;
         m_valid <= 1'b0;
         m_stall <= `LC4_STALL_NONE;
         w_insn  <= '0;
         w_ctrl  <= '0;
         w_valid <= 1'b0;
         w_stall <= `LC4_STALL_NONE;
      end else begin
         m_insn  <= x_insn;
         m_ctrl  <= x_ctrl;
         m_valid <= x_valid;
         m_stall <= x_stall;
         w_insn  <= m_insn;
         w_ctrl  <= m_ctrl;
         w_valid <= m_valid;
         w_stall <= m_stall;
      end
   end

   always_ff @(posedge gwe) begin
      m_pc         <= x_pc;
      m_result     <= x_result;
      m_store_data <= x_rt_fwd;   // store data after MX/WX
      w_pc         <= m_pc;
      w_result     <= m_result;
      w_load_data  <= i_dmem_rdata;
   end

   assign o_dmem_addr = m_result;
   assign o_dmem_we   = m_ctrl.is_store;

   assign wb.we   = w_ctrl.regfile_we;
   assign wb.wsel = w_ctrl.wsel;
   assign wb.data = w_ctrl.is_load ? w_load_data : w_result;
   assign wb.load = w_ctrl.is_load;

   assign o_wb_valid = w_valid;
   assign o_wb_pc    = w_pc;
   assign o_wb_insn  = w_insn;
   assign o_wb_we    = wb.we;
   assign o_wb_wsel  = wb.wsel;
   assign o_wb_data  = wb.data;
   assign o_wb_stall = w_stall;

endmodule

`default_nettype wire

/* tb/lc4_core_assert.sv */
`default_nettype none

module lc4_core_assert (
   input wire logic        gwe,
   input wire logic        i_rst_n,
   input wire logic        o_dmem_we,
   input wire logic        o_wb_we,
   input wire logic [1:0]  o_wb_stall,
   input wire logic [15:0] o_wb_data
);

   timeunit 1ns;
   timeprecision 100ps;

   // a cycle in reset leaves no store and no register write behind it
   a_quiet_after_reset: assert property (@(posedge gwe)
      !i_rst_n |=> (!o_dmem_we && !o_wb_we))
      else $error("store or register write right after reset");

   a_stall_no_write: assert property (@(posedge gwe) disable iff (!i_rst_n)
      (o_wb_stall != 2'd0) |-> !o_wb_we)
      else $error("stalled slot writes a register");

   a_wb_data_known: assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_wb_we |-> !$isunknown(o_wb_data))
      else $error("writeback data has unknown bits");

endmodule

`default_nettype wire

/* tb/lc4_core_tb.sv */
`include "lc4_defines.svh"
`default_nettype none

module lc4_core_tb import lc4_isa_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   logic        gwe;
   logic        i_rst_n;
   logic [15:0] o_imem_addr, i_imem_data, o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
   logic        o_dmem_we, o_wb_valid, o_wb_we;
   logic [15:0] o_wb_pc, o_wb_insn, o_wb_data;
   logic [2:0]  o_wb_wsel;
   logic [1:0]  o_wb_stall;

   logic [15:0] imem [64];
   logic [15:0] dmem [65536];
   logic [15:0] mdl_mem [65536];
   logic [15:0] imem_idx;
   logic [18:0] exp_wr [$];   // {wsel, data}
   logic [31:0] exp_st [$];   // {addr, data}
   logic [31:0] exp_tr [$];   // {pc, insn}
   int          errors, checks, exp_ld, exp_br, n_ld, n_br;
   logic        mon_on;

   lc4_core u_lc4_core (.*);

   bind lc4_core lc4_core_assert u_core_assert (
      .gwe(gwe), .i_rst_n(i_rst_n), .o_dmem_we(o_dmem_we), .o_wb_we(o_wb_we),
      .o_wb_stall(o_wb_stall), .o_wb_data(o_wb_data));

   always #20 gwe = ~gwe;

   // both memories answer in the same cycle
   assign imem_idx     = o_imem_addr - `LC4_BOOT_PC;
   assign i_imem_data  = (imem_idx < 16'd64) ? imem[imem_idx[5:0]] : 16'h0000;
   assign i_dmem_rdata = dmem[o_dmem_addr];

   always @(posedge gwe) begin
      if (o_dmem_we) dmem[o_dmem_addr] <= o_dmem_wdata;
   end

   task automatic expect_eq(input string msg, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %0t: %s expected %h got %h", $time, msg, exp, act);
      end
   endtask

   // trace monitor samples at mid-cycle
   always @(negedge gwe) begin
      logic [18:0] w;
      logic [31:0] s;
      logic [31:0] tr;
      if (mon_on && o_wb_valid) begin
         if (o_wb_stall == `LC4_STALL_LOAD) n_ld++;
         if (o_wb_stall == `LC4_STALL_BRANCH) n_br++;
         if (o_wb_stall == `LC4_STALL_NONE && exp_tr.size() != 0) begin
            tr = exp_tr.pop_front();
            expect_eq("wb pc", tr[31:16], o_wb_pc);
            expect_eq("wb insn", tr[15:0], o_wb_insn);
         end
      end
      if (mon_on && o_wb_we) begin
         if (exp_wr.size() == 0) begin
            errors++;
            $display("register write at %0t that the model did not expect", $time);
         end else begin
            w = exp_wr.pop_front();
            expect_eq("wb wsel", {13'd0, w[18:16]}, {13'd0, o_wb_wsel});
            expect_eq("wb data", w[15:0], o_wb_data);
         end
      end
      if (mon_on && o_dmem_we) begin
         if (exp_st.size() == 0) begin
            errors++;
            $display("store at %0t that the model did not expect", $time);
         end else begin
            s = exp_st.pop_front();
            expect_eq("store addr", s[31:16], o_dmem_addr);
            expect_eq("store data", s[15:0], o_dmem_wdata);
         end
      end
   end

   function automatic logic [15:0] fill_word(input logic [15:0] a);
      return (a * 16'd40503) ^ 16'h3c5a;
   endfunction

   function automatic nzp_t nzp_of(input logic [15:0] v);
      return {v[15], v == 16'd0, !v[15] && v != 16'd0};
   endfunction

   function automatic logic [15:0] add_rr(input logic [2:0] d, s, t);
      return {4'h1, d, s, 3'b000, t};
   endfunction
   function automatic logic [15:0] sub_rr(input logic [2:0] d, s, t);
      return {4'h1, d, s, 3'b010, t};
   endfunction
   function automatic logic [15:0] and_rr(input logic [2:0] d, s, t);
      return {4'h5, d, s, 3'b000, t};
   endfunction
   function automatic logic [15:0] add_imm(input logic [2:0] d, s, input logic [4:0] i);
      return {4'h1, d, s, 1'b1, i};
   endfunction
   function automatic logic [15:0] const_insn(input logic [2:0] d, input logic [8:0] i);
      return {4'h9, d, i};
   endfunction
   function automatic logic [15:0] load_insn(input logic [2:0] d, s, input logic [5:0] i);
      return {4'h6, d, s, i};
   endfunction
   function automatic logic [15:0] store_insn(input logic [2:0] t, s, input logic [5:0] i);
      return {4'h7, t, s, i};
   endfunction
   function automatic logic [15:0] branch_insn(input logic [2:0] m, input logic [8:0] i);
      return {4'h0, m, i};
   endfunction

   // sequential LC4 subset model that fills the expected queues and stall counts
   task automatic model_run(input int n);
      logic [15:0] r [8];
      logic [15:0] pc, insn, a, v;
      nzp_t        nzp;
      logic [2:0]  rd, rs, rt, ld_rd;
      logic        ld_pend, use_rs, use_rt, wr;
      int          steps;
      for (int i = 0; i < 8; i++) r[i] = 16'd0;
      nzp = '0;
      ld_pend = 1'b0;
      ld_rd = 3'd0;
      steps = 0;
      pc = `LC4_BOOT_PC;
      while (pc - `LC4_BOOT_PC < n && steps < 1000) begin
         insn = imem[pc - `LC4_BOOT_PC];
         exp_tr.push_back({pc, insn});
         rd = insn[11:9];
         rs = insn[8:6];
         rt = insn[2:0];
         use_rs = 1'b0;
         use_rt = 1'b0;
         wr = 1'b0;
         v = 16'd0;
         case (insn[15:12])
            4'h0: if ((insn[11:9] & nzp) != 3'b000) begin
               pc = pc + {{7{insn[8]}}, insn[8:0]};
               exp_br += 2;
            end
            4'h1: begin
               use_rs = 1'b1;
               use_rt = !insn[5];
               wr = 1'b1;
               if (insn[5]) v = r[rs] + {{11{insn[4]}}, insn[4:0]};
               else if (insn[4]) v = r[rs] - r[rt];
               else v = r[rs] + r[rt];
            end
            4'h5: begin
               use_rs = 1'b1;
               use_rt = 1'b1;
               wr = 1'b1;
               v = r[rs] & r[rt];
            end
            4'h6: begin
               use_rs = 1'b1;
               a = r[rs] + {{10{insn[5]}}, insn[5:0]};
               r[rd] = mdl_mem[a];   // loads leave nzp alone
               exp_wr.push_back({rd, mdl_mem[a]});
            end
            4'h7: begin
               use_rs = 1'b1;
               a = r[rs] + {{10{insn[5]}}, insn[5:0]};
               mdl_mem[a] = r[rd];
               exp_st.push_back({a, r[rd]});
            end
            4'h9: begin
               wr = 1'b1;
               v = {{7{insn[8]}}, insn[8:0]};
            end
            default: ;
         endcase
         if (wr) begin
            r[rd] = v;
            nzp = nzp_of(v);
            exp_wr.push_back({rd, v});
         end
         if (ld_pend && ((use_rs && rs == ld_rd) || (use_rt && rt == ld_rd))) exp_ld++;
         ld_pend = (insn[15:12] == 4'h6);
         ld_rd = rd;
         pc = pc + 16'd1;
         steps++;
      end
   endtask

   task automatic apply_reset();
      @(posedge gwe);
      i_rst_n <= 1'b0;
      repeat (8) @(posedge gwe);
      i_rst_n <= 1'b1;
   endtask

   // runs imem[0..n-1] up to the NOP at n
   task automatic run_program(input int n, input string name);
      int cnt;
      mon_on = 1'b0;
      exp_wr.delete();
      exp_st.delete();
      exp_tr.delete();
      {exp_ld, exp_br, n_ld, n_br} = '0;
      for (int a = 0; a < 65536; a++) begin
         dmem[a] = fill_word(16'(a));
         mdl_mem[a] = fill_word(16'(a));
      end
      model_run(n);
      apply_reset();
      @(negedge gwe);
      mon_on = 1'b1;
      expect_eq({name, " boot fetch"}, `LC4_BOOT_PC, o_imem_addr);
      cnt = 0;
      while (!o_wb_valid && cnt < 20) begin
         @(negedge gwe);
         cnt++;
      end
      if (cnt >= 20) begin
         errors++;
         $display("%s timed out waiting for the first trace slot", name);
      end else begin
         expect_eq({name, " cycles to first trace"}, 16'd4, 16'(cnt));
      end
      cnt = 0;
      while (!(o_wb_valid && o_wb_stall == 2'd0 && o_wb_pc == `LC4_BOOT_PC + 16'(n))
             && cnt < 500) begin
         @(negedge gwe);
         cnt++;
      end
      if (cnt >= 500) begin
         errors++;
         $display("%s timed out waiting for the end of the program", name);
      end
      mon_on = 1'b0;
      expect_eq({name, " writes left"}, 16'd0, 16'(exp_wr.size()));
      expect_eq({name, " stores left"}, 16'd0, 16'(exp_st.size()));
      expect_eq({name, " trace left"}, 16'd0, 16'(exp_tr.size()));
      expect_eq({name, " load stalls"}, 16'(exp_ld), 16'(n_ld));
      expect_eq({name, " branch flushes"}, 16'(exp_br), 16'(n_br));
   endtask

   task automatic forwarding_chain();
      for (int i = 0; i < 64; i++) imem[i] = 16'h0000;
      imem[0] = const_insn(3'd1, 9'd5);
      imem[1] = const_insn(3'd2, 9'h1fd);
      imem[2] = add_rr(3'd3, 3'd1, 3'd2);
      imem[3] = sub_rr(3'd4, 3'd3, 3'd1);
      imem[4] = and_rr(3'd5, 3'd4, 3'd3);
      imem[5] = add_imm(3'd6, 3'd5, 5'h19);
      imem[6] = add_rr(3'd7, 3'd6, 3'd6);
      imem[7] = sub_rr(3'd1, 3'd7, 3'd2);
      run_program(8, "forwarding");
   endtask

   task automatic load_store_pair();
      for (int i = 0; i < 64; i++) imem[i] = 16'h0000;
      imem[0] = const_insn(3'd1, 9'd16);
      imem[1] = load_insn(3'd2, 3'd1, 6'd3);
      imem[2] = add_rr(3'd3, 3'd2, 3'd2);     // load-use
      imem[3] = load_insn(3'd4, 3'd1, 6'h3e);
      imem[4] = store_insn(3'd4, 3'd1, 6'd5); // WM path
      imem[5] = add_rr(3'd5, 3'd4, 3'd1);
      run_program(6, "load_store");
   endtask

   task automatic branch_flush();
      for (int i = 0; i < 64; i++) imem[i] = 16'h0000;
      imem[0] = const_insn(3'd1, 9'd0);
      imem[1] = branch_insn(3'b010, 9'd2);    // taken on z
      imem[2] = const_insn(3'd2, 9'd1);
      imem[3] = const_insn(3'd3, 9'd2);
      imem[4] = const_insn(3'd4, 9'd3);
      imem[5] = branch_insn(3'b100, 9'd1);    // not taken
      imem[6] = 16'h0000;
      imem[7] = add_rr(3'd5, 3'd4, 3'd4);
      run_program(8, "branches");
   endtask

   task automatic random_arith();
      logic [2:0] d, s, t;
      for (int i = 0; i < 64; i++) imem[i] = 16'h0000;
      for (int i = 0; i < 40; i++) begin
         d = 3'($urandom);
         s = 3'($urandom);
         t = 3'($urandom);
         case ($urandom % 5)
            0: imem[i] = add_rr(d, s, t);
            1: imem[i] = sub_rr(d, s, t);
            2: imem[i] = and_rr(d, s, t);
            3: imem[i] = add_imm(d, s, 5'($urandom));
            default: imem[i] = const_insn(d, 9'($urandom));
         endcase
      end
      run_program(40, "random");
   endtask

   initial begin
      gwe = 1'b0;
      i_rst_n = 1'b0;
      mon_on = 1'b0;
      errors = 0;
      checks = 0;
      void'($urandom(47087));
      forwarding_chain();
      load_store_pair();
      branch_flush();
      random_arith();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
design/lc4_isa_pkg.sv
design/lc4_pipe_pkg.sv
design/lc4_wb_if.sv
design/lc4_decoder.sv
design/lc4_alu.sv
design/lc4_regfile.sv
design/lc4_hazard_unit.sv
design/lc4_branch_unit.sv
design/lc4_core.sv
tb/lc4_core_assert.sv
tb/lc4_core_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the lc4_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module lc4_core_tb -o sim_lc4 > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "compile failed, see build.log"
   exit 1
fi

./obj_dir/sim_lc4 > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
   exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
